// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# a $fatal in the testbench makes the binary exit nonzero
sim: build
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rvPkg::*; (
	input  wire logic [31:0] srcA,
	input  wire logic [31:0] srcB,
	input  wire aluOpE       aluOp,
	input  wire logic [2:0]  funct3,
	output logic      [31:0] result,
	output logic             branchTaken
);

	logic [4:0] shamt;
	logic       lessS;
	logic       lessU;
	logic       equal;

	assign shamt = srcB[4:0];
	assign lessS = $signed(srcA) < $signed(srcB);
	assign lessU = srcA < srcB;
	assign equal = srcA == srcB;

	always_comb begin
		case (aluOp)
			aluAdd:   result = srcA + srcB;
			aluSub:   result = srcA - srcB;
			aluSll:   result = srcA << shamt;
			aluSlt:   result = {31'b0, lessS};
			aluSltu:  result = {31'b0, lessU};
			aluXor:   result = srcA ^ srcB;
			aluSrl:   result = srcA >> shamt;
			aluSra:   result = $unsigned($signed(srcA) >>> shamt);
			aluOr:    result = srcA | srcB;
			aluAnd:   result = srcA & srcB;
			aluPassB: result = srcB;
			default:  result = '0;
		endcase
	end

	// only looked at by pcUnit on branch kinds
	always_comb begin
		case (funct3)
			3'b000:  branchTaken = equal;  // beq
			3'b001:  branchTaken = !equal; // bne
			3'b100:  branchTaken = lessS;
			3'b101:  branchTaken = !lessS;
			3'b110:  branchTaken = lessU;
			3'b111:  branchTaken = !lessU;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import rvPkg::*; #(
	parameter logic [31:0] resetVector = defaultResetVector
) (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire logic [31:0] inst,
	input  wire logic [31:0] readData,
	output logic      [31:0] pc,
	output logic      [31:0] dataAddr,
	output logic      [31:0] storeData,
	output accessLenE        dataLen,
	output logic             memWrite,
	output logic             memRead,
	output logic             halt
);

	aluOpE       aluOp;
	logic        aluSrcImm;
	logic        regWrite;
	wbSelE       wbSel;
	pcKindE      pcKind;
	logic        decMemWrite;
	logic        dataSigned;
	logic [31:0] imm;
	logic        isEbreak;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic        branchTaken;
	logic [31:0] pcPlus4;
	logic [31:0] pcPlusImm;
	logic [31:0] loadData;
	logic [31:0] writeData;

	assign srcB      = aluSrcImm ? imm : rs2Data;
	assign dataAddr  = aluResult;
	assign storeData = rs2Data;
	assign memWrite  = decMemWrite & ~halt; // no stores once halted

	// low lanes only, no misaligned support
	always_comb begin
		case (dataLen)
			lenByte: loadData = {{24{dataSigned & readData[7]}}, readData[7:0]};
			lenHalf: loadData = {{16{dataSigned & readData[15]}}, readData[15:0]};
			default: loadData = readData;
		endcase
	end

	always_comb begin
		case (wbSel)
			wbMem:     writeData = loadData;
			wbPcPlus4: writeData = pcPlus4;   // link
			wbPcImm:   writeData = pcPlusImm; // auipc
			default:   writeData = aluResult;
		endcase
	end

	pcUnit #(.resetVector(resetVector)) i_pcUnit (
		.clk        (clk),
		.rstN       (rstN),
		.pcKind     (pcKind),
		.branchTaken(branchTaken),
		.imm        (imm),
		.jalrTarget (aluResult),
		.isEbreak   (isEbreak),
		.pc         (pc),
		.pcPlus4    (pcPlus4),
		.pcPlusImm  (pcPlusImm),
		.halt       (halt)
	);

	decoder i_decoder (
		.inst      (inst),
		.aluOp     (aluOp),
		.aluSrcImm (aluSrcImm),
		.regWrite  (regWrite),
		.wbSel     (wbSel),
		.pcKind    (pcKind),
		.memWrite  (decMemWrite),
		.memRead   (memRead),
		.dataLen   (dataLen),
		.dataSigned(dataSigned),
		.imm       (imm),
		.isEbreak  (isEbreak)
	);

	regFile i_regFile (
		.clk      (clk),
		.rstN     (rstN),
		.rs1      (inst[19:15]),
		.rs2      (inst[24:20]),
		.rd       (inst[11:7]),
		.writeData(writeData),
		.writeEn  (regWrite & ~halt),
		.rs1Data  (rs1Data),
		.rs2Data  (rs2Data)
	);

	alu i_alu (
		.srcA       (rs1Data),
		.srcB       (srcB),
		.aluOp      (aluOp),
		.funct3     (inst[14:12]),
		.result     (aluResult),
		.branchTaken(branchTaken)
	);

endmodule

`default_nettype wire

// File: design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import rvPkg::*; (
	input  wire logic [31:0] inst,
	output aluOpE            aluOp,
	output logic             aluSrcImm,
	output logic             regWrite,
	output wbSelE            wbSel,
	output pcKindE           pcKind,
	output logic             memWrite,
	output logic             memRead,
	output accessLenE        dataLen,
	output logic             dataSigned,
	output logic      [31:0] imm,
	output logic             isEbreak
);

	opcodeE      opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;

	// alt selects sub / sra
	function automatic aluOpE aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? aluSub : aluAdd;
			3'b001:  return aluSll;
			3'b010:  return aluSlt;
			3'b011:  return aluSltu;
			3'b100:  return aluXor;
			3'b101:  return alt ? aluSra : aluSrl;
			3'b110:  return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	function automatic accessLenE lenFromFunct3(input logic [1:0] f);
		case (f)
			2'b00:   return lenByte;
			2'b01:   return lenHalf;
			default: return lenWord;
		endcase
	endfunction

	assign opcode = opcodeE'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign isEbreak = (inst == 32'h0010_0073);

	always_comb begin
		// nop unless the opcode says otherwise
		aluOp      = aluAdd;
		aluSrcImm  = 1'b0;
		regWrite   = 1'b0;
		wbSel      = wbAlu;
		pcKind     = kindSeq;
		memWrite   = 1'b0;
		memRead    = 1'b0;
		dataLen    = lenWord;
		dataSigned = 1'b0;
		imm        = immI;
		case (opcode)
			opLoad: begin
				aluSrcImm  = 1'b1;
				regWrite   = 1'b1;
				wbSel      = wbMem;
				memRead    = 1'b1;
				dataLen    = lenFromFunct3(funct3[1:0]);
				dataSigned = ~funct3[2]; // lbu/lhu have bit 2 set
			end
			opStore: begin
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
				dataLen   = lenFromFunct3(funct3[1:0]);
				imm       = immS;
			end
			opOpImm: begin
				// only srai looks at funct7
				aluOp     = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
			end
			opOp: begin
				aluOp    = aluFromFunct3(funct3, funct7[5]);
				regWrite = 1'b1;
			end
			opLui: begin
				aluOp     = aluPassB;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				imm       = immU;
			end
			opAuipc: begin
				regWrite = 1'b1;
				wbSel    = wbPcImm;
				imm      = immU;
			end
			opJal: begin
				regWrite = 1'b1;
				wbSel    = wbPcPlus4;
				pcKind   = kindJal;
				imm      = immJ;
			end
			opJalr: begin
				aluSrcImm = 1'b1; // target = rs1 + imm
				regWrite  = 1'b1;
				wbSel     = wbPcPlus4;
				pcKind    = kindJalr;
			end
			opBranch: begin
				pcKind = kindBranch; // alu compares rs1 and rs2
				imm    = immB;
			end
			opSystem: begin
				// ebreak is flagged above
			end
			default: begin
			end
		endcase
	end

	// lb lh lw lbu lhu sb sh sw are the only widths rv32i has
	always_comb begin
		lenLegal: assert #0 (!(memRead || memWrite) || funct3 inside {3'b000, 3'b001, 3'b010}
			|| (memRead && funct3 inside {3'b100, 3'b101}))
			else $error("illegal access width, funct3 %b", funct3);
	end

endmodule

`default_nettype wire

// File: design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit import rvPkg::*; #(
	parameter logic [31:0] resetVector = defaultResetVector
) (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire pcKindE      pcKind,
	input  wire logic        branchTaken,
	input  wire logic [31:0] imm,
	input  wire logic [31:0] jalrTarget,
	input  wire logic        isEbreak,
	output logic      [31:0] pc,
	output logic      [31:0] pcPlus4,
	output logic      [31:0] pcPlusImm,
	output logic             halt
);

	pcSelE       pcSel;
	logic [31:0] nextPc;

	assign pcPlus4   = pc + 32'd4;
	assign pcPlusImm = pc + imm; // branch and jal target, also auipc

	always_comb begin
		pcSel = pcSeq;
		if (pcKind == kindJal || (pcKind == kindBranch && branchTaken))
			pcSel = pcBranch;
		else if (pcKind == kindJalr)
			pcSel = pcJalr;
	end

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = pcPlusImm;
			pcJalr:   nextPc = {jalrTarget[31:1], 1'b0};
			default:  nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc   <= resetVector;
			halt <= 1'b0;
		end else begin
			if (isEbreak)
				halt <= 1'b1; // sticky until reset
			if (!halt && !isEbreak)
				pc <= nextPc;
		end
	end

	// jalr targets with bit 1 set would break this
	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire logic        clk,
	input  wire logic        rstN,
	input  wire logic [4:0]  rs1,
	input  wire logic [4:0]  rs2,
	input  wire logic [4:0]  rd,
	input  wire logic [31:0] writeData,
	input  wire logic        writeEn,
	output logic      [31:0] rs1Data,
	output logic      [31:0] rs2Data
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEn && rd != 5'd0) begin
			regs[rd] <= writeData; // x0 never written
		end
	end

	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	// x0 stays zero only because no write ever lands there
	x0Zero: assert property (@(posedge clk) disable iff (!rstN)
		(rs1 == 5'd0) |-> (rs1Data == '0))
		else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: design/rvPkg.sv
`default_nettype none

package rvPkg;

	// rv32i major opcodes
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opOpImm  = 7'b0010011,
		opOp     = 7'b0110011,
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opSystem = 7'b1110011
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB // lui
	} aluOpE;

	typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4, wbPcImm} wbSelE;

	// same codes the memory side expects: 0 1 3
	typedef enum logic [1:0] {lenByte = 2'd0, lenHalf = 2'd1, lenWord = 2'd3} accessLenE;

	typedef enum logic [1:0] {pcSeq, pcBranch, pcJalr} pcSelE;

	// what the decoder knows about control flow
	typedef enum logic [1:0] {kindSeq, kindBranch, kindJal, kindJalr} pcKindE;

	parameter logic [31:0] defaultResetVector = 32'h8000_0000;

endpackage

`default_nettype wire

// File: filelist.f
design/rvPkg.sv
design/pcUnit.sv
design/decoder.sv
design/regFile.sv
design/alu.sv
design/cpuTop.sv
tb/tbCpu.sv

// File: tb/cpuGolden.hex
// inst readData | expected: pc dataAddr storeData memWrite memRead dataLen halt
// dataAddr is compared on loads and stores only, storeData on stores only
12300093 00000000 80000000 00000000 00000000 0 0 3 0
fff00113 00000000 80000004 00000000 00000000 0 0 3 0
123451b7 00000000 80000008 00000000 00000000 0 0 3 0
0011a023 00000000 8000000c 12345000 00000123 1 0 3 0
00208233 00000000 80000010 00000000 00000000 0 0 3 0
402082b3 00000000 80000014 00000000 00000000 0 0 3 0
0041a223 00000000 80000018 12345004 00000122 1 0 3 0
0051a423 00000000 8000001c 12345008 00000124 1 0 3 0
00112333 00000000 80000020 00000000 00000000 0 0 3 0
001133b3 00000000 80000024 00000000 00000000 0 0 3 0
0f00c413 00000000 80000028 00000000 00000000 0 0 3 0
01709513 00000000 8000002c 00000000 00000000 0 0 3 0
40855593 00000000 80000030 00000000 00000000 0 0 3 0
00855613 00000000 80000034 00000000 00000000 0 0 3 0
00c466b3 00000000 80000038 00000000 00000000 0 0 3 0
00d5c733 00000000 8000003c 00000000 00000000 0 0 3 0
0061a623 00000000 80000040 1234500c 00000001 1 0 3 0
00719823 00000000 80000044 12345010 00000000 1 0 1 0
feb18fa3 00000000 80000048 12344fff ff918000 1 0 0 0
00e62023 00000000 8000004c 00918000 ff0001d3 1 0 3 0
00500013 00000000 80000050 00000000 00000000 0 0 3 0
0001aa23 00000000 80000054 12345014 00000000 1 0 3 0
00018783 123456f0 80000058 12345000 00000000 0 1 0 0
0001c803 123456f0 8000005c 12345000 00000000 0 1 0 0
00419883 abcd8765 80000060 12345004 00000000 0 1 1 0
0041d903 abcd8765 80000064 12345004 00000000 0 1 1 0
0081a983 cafe1234 80000068 12345008 00000000 0 1 3 0
0117a023 00000000 8000006c fffffff0 ffff8765 1 0 3 0
01282023 00000000 80000070 000000f0 00008765 1 0 3 0
0131a023 00000000 80000074 12345000 cafe1234 1 0 3 0
00208863 00000000 80000078 00000000 00000000 0 0 3 0
00114663 00000000 8000007c 00000000 00000000 0 0 3 0
fe117ce3 00000000 80000088 00000000 00000000 0 0 3 0
01000a6f 00000000 80000080 00000000 00000000 0 0 3 0
015a0ae7 00000000 80000090 00000000 00000000 0 0 3 0
015a2023 00000000 80000098 80000084 80000094 1 0 3 0
00100073 00000000 8000009c 00000000 00000000 0 0 3 0
00700093 00000000 8000009c 00000000 00000000 0 0 3 1
0011a023 00000000 8000009c 12345000 00000123 0 0 3 1

// File: tb/tbCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

	localparam int numLines   = 39;
	localparam int numCols    = 9;
	localparam int cycleLimit = numLines + 20;
	localparam int driveDelay = 1;
	localparam int checkDelay = 17; // lands 2 ns before the next edge

	logic        clk;
	logic        rstN;
	logic [31:0] inst;
	logic [31:0] readData;
	logic [31:0] pc;
	logic [31:0] dataAddr;
	logic [31:0] storeData;
	logic [1:0]  dataLen;
	logic        memWrite;
	logic        memRead;
	logic        halt;

	// one row per cycle, columns as in the hex file
	logic [31:0] golden [numLines * numCols];
	int          cycleCount = 0;

	cpuTop i_dut (
		.clk      (clk),
		.rstN     (rstN),
		.inst     (inst),
		.readData (readData),
		.pc       (pc),
		.dataAddr (dataAddr),
		.storeData(storeData),
		.dataLen  (dataLen),
		.memWrite (memWrite),
		.memRead  (memRead),
		.halt     (halt)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("run did not finish within %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected, input int line);
		assert (got === expected) else begin
			$display("mismatch %s expected %h got %h (line %0d)", name, expected, got, line);
			$display("TESTBENCH FAILED");
			$fatal(1, "output check failed");
		end
	endtask

	initial begin
		int   base;
		logic isLoad;
		logic isStore;
		clk      = 1'b0;
		rstN     = 1'b0;
		inst     = 32'h0000_0013; // addi x0, x0, 0
		readData = '0;
		$readmemh("tb/cpuGolden.hex", golden);
		assert (golden[2] != '0) else begin
			$display("golden file is missing or holds no program");
			$display("TESTBENCH FAILED");
			$fatal(1, "no stimulus");
		end
		repeat (2) @(posedge clk);
		#(driveDelay);
		rstN = 1'b1;
		for (int line = 0; line < numLines; line++) begin
			base     = line * numCols;
			inst     = golden[base];
			readData = golden[base + 1];
			isStore  = inst[6:0] == 7'h23;
			isLoad   = inst[6:0] == 7'h03;
			#(checkDelay);
			checkValue("pc", pc, golden[base + 2], line);
			if (isStore || isLoad)
				checkValue("dataAddr", dataAddr, golden[base + 3], line);
			if (isStore)
				checkValue("storeData", storeData, golden[base + 4], line);
			checkValue("memWrite", {31'b0, memWrite}, golden[base + 5], line);
			checkValue("memRead", {31'b0, memRead}, golden[base + 6], line);
			checkValue("dataLen", {30'b0, dataLen}, golden[base + 7], line);
			checkValue("halt", {31'b0, halt}, golden[base + 8], line);
			@(posedge clk);
			#(driveDelay);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire
